// ==== hdl/fast_pkg.sv ====
`default_nettype none

package fast_pkg;

    // image geometry
    localparam int IMG_WIDTH  = 32;
    localparam int IMG_HEIGHT = 24;

    // circle and detector constants
    localparam int CIRCLE_RADIUS  = 3;
    localparam int CIRCLE_POINTS  = 16;
    localparam int WIN_SIZE       = 2 * CIRCLE_RADIUS + 1;
    localparam int BORDER         = 3;
    localparam int FAST_THRESHOLD = 20;
    localparam int ARC_MIN        = 9;

    // pixels accepted before the first centre has its full window
    localparam int WINDOW_LEAD = 3 * IMG_WIDTH + 3;

    // bresenham circle offsets clockwise from the top
    localparam int CIRCLE_DX [CIRCLE_POINTS] = '{0, 1, 2, 3, 3, 3, 2, 1,
                                                 0, -1, -2, -3, -3, -3, -2, -1};
    localparam int CIRCLE_DY [CIRCLE_POINTS] = '{-3, -3, -2, -1, 0, 1, 2, 3,
                                                 3, 3, 2, 1, 0, -1, -2, -3};

    typedef logic [7:0] pixel_t;
    typedef logic [5:0] coord_t;
    typedef logic [4:0] arc_len_t;
    typedef logic [$clog2(WINDOW_LEAD + 1)-1:0] lead_count_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } coord_pair_t;

    typedef struct packed {
        pixel_t [CIRCLE_POINTS-1:0] circle;
        pixel_t                     center;
        coord_pair_t                pos;
        logic                       last;
    } window_t;

    typedef struct packed {
        arc_len_t    score;
        coord_pair_t pos;
        logic        last;
    } seg_result_t;

    typedef enum logic [1:0] {
        S_IDLE,
        S_FILL,
        S_WORK
    } frame_state_t;

endpackage

`default_nettype wire

// ==== hdl/fast_window.sv ====
`timescale 1ns/1ns
`default_nettype none

module fast_window
    import fast_pkg::*;
(
    input  wire    i_clk,
    input  wire    i_rst_n,
    input  wire    pixel_t i_pixel,
    input  wire    i_valid,
    input  wire    i_start,
    output logic   o_ready,
    output window_t o_win,
    output logic   o_win_valid
);

    frame_state_t state_r, state_w;
    lead_count_t  count_r, count_w;
    coord_t       cx_r, cx_w;
    coord_t       cy_r, cy_w;

    logic        accept;
    logic        emit;
    logic        emit_last;
    logic        emit_r;
    coord_pair_t emit_pos_r;
    logic        emit_last_r;

    // row delay lines with the oldest row at index 0
    pixel_t line_buf [WIN_SIZE-1][IMG_WIDTH];
    pixel_t win [WIN_SIZE][WIN_SIZE];

    assign o_ready = (state_r == S_IDLE);
    assign accept  = i_valid && ((state_r != S_IDLE) || i_start);

    always_comb begin
        state_w   = state_r;
        count_w   = count_r;
        cx_w      = cx_r;
        cy_w      = cy_r;
        emit      = 1'b0;
        emit_last = 1'b0;
        case (state_r)
            S_IDLE: begin
                if (i_valid && i_start) begin
                    state_w = S_FILL;
                    count_w = lead_count_t'(1);
                    cx_w    = '0;
                    cy_w    = '0;
                end
            end
            S_FILL: begin
                if (i_valid) begin
                    if (count_r == lead_count_t'(WINDOW_LEAD)) begin
                        emit    = 1'b1;
                        state_w = S_WORK;
                    end else begin
                        count_w = count_r + 1'b1;
                    end
                end
            end
            S_WORK: begin
                emit = i_valid;
            end
            default: begin
                state_w = S_IDLE;
            end
        endcase

        // advance the centre coordinate on every emitted window
        if (emit) begin
            emit_last = (cx_r == coord_t'(IMG_WIDTH - 1)) &&
                        (cy_r == coord_t'(IMG_HEIGHT - 1));
            if (cx_r == coord_t'(IMG_WIDTH - 1)) begin
                cx_w = '0;
                cy_w = cy_r + 1'b1;
            end else begin
                cx_w = cx_r + 1'b1;
            end
            if (emit_last) begin
                state_w = S_IDLE;
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_r     <= S_IDLE;
            count_r     <= '0;
            cx_r        <= '0;
            cy_r        <= '0;
            emit_r      <= 1'b0;
            o_win_valid <= 1'b0;
        end else begin
            state_r     <= state_w;
            count_r     <= count_w;
            cx_r        <= cx_w;
            cy_r        <= cy_w;
            emit_r      <= emit;
            o_win_valid <= emit_r;
        end
    end

    // line buffers and window only move on accepted pixels
    always_ff @(posedge i_clk) begin
        if (accept) begin
            for (int r = 0; r < WIN_SIZE - 1; r++) begin
                if (r == WIN_SIZE - 2) begin
                    line_buf[r][0] <= i_pixel;
                end else begin
                    line_buf[r][0] <= line_buf[r+1][IMG_WIDTH-1];
                end
                for (int i = 1; i < IMG_WIDTH; i++) begin
                    line_buf[r][i] <= line_buf[r][i-1];
                end
            end
            for (int r = 0; r < WIN_SIZE; r++) begin
                for (int c = 0; c < WIN_SIZE - 1; c++) begin
                    win[r][c] <= win[r][c+1];
                end
            end
            for (int r = 0; r < WIN_SIZE - 1; r++) begin
                win[r][WIN_SIZE-1] <= line_buf[r][IMG_WIDTH-1];
            end
            win[WIN_SIZE-1][WIN_SIZE-1] <= i_pixel;
        end
        if (emit) begin
            emit_pos_r.x <= cx_r;
            emit_pos_r.y <= cy_r;
            emit_last_r  <= emit_last;
        end
    end

    // pick circle and centre one cycle after the completing pixel
    always_ff @(posedge i_clk) begin
        if (emit_r) begin
            for (int i = 0; i < CIRCLE_POINTS; i++) begin
                o_win.circle[i] <= win[CIRCLE_RADIUS + CIRCLE_DY[i]][CIRCLE_RADIUS + CIRCLE_DX[i]];
            end
            o_win.center <= win[CIRCLE_RADIUS][CIRCLE_RADIUS];
            o_win.pos    <= emit_pos_r;
            o_win.last   <= emit_last_r;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/fast_segment_test.sv ====
`timescale 1ns/1ns
`default_nettype none

module fast_segment_test
    import fast_pkg::*;
(
    input  wire         i_clk,
    input  wire         i_rst_n,
    input  wire window_t i_win,
    input  wire         i_win_valid,
    output seg_result_t o_seg,
    output logic        o_seg_valid
);

    // longest circular run of set bits
    function automatic arc_len_t longest_arc(input logic [CIRCLE_POINTS-1:0] marks);
        logic [2*CIRCLE_POINTS-1:0] doubled;
        arc_len_t                   run;
        arc_len_t                   best;
        doubled = {marks, marks};
        run     = '0;
        best    = '0;
        if (&marks) begin
            best = arc_len_t'(CIRCLE_POINTS);
        end else begin
            for (int i = 0; i < 2 * CIRCLE_POINTS; i++) begin
                if (doubled[i]) begin
                    run = run + 1'b1;
                end else begin
                    run = '0;
                end
                if (run > best) begin
                    best = run;
                end
            end
        end
        return best;
    endfunction

    pixel_t                   hi_th;
    pixel_t                   lo_th;
    logic [8:0]               hi_sum;
    logic [CIRCLE_POINTS-1:0] bright_w;
    logic [CIRCLE_POINTS-1:0] dark_w;

    logic                     s1_valid_r;
    logic [CIRCLE_POINTS-1:0] s1_bright_r;
    logic [CIRCLE_POINTS-1:0] s1_dark_r;
    coord_pair_t              s1_pos_r;
    logic                     s1_last_r;

    arc_len_t bright_len;
    arc_len_t dark_len;
    arc_len_t best_len;
    arc_len_t score_w;

    // stage 1 with saturating thresholds around the centre
    always_comb begin
        hi_sum = {1'b0, i_win.center} + 9'(FAST_THRESHOLD);
        hi_th  = hi_sum[8] ? 8'hff : hi_sum[7:0];
        if (i_win.center < pixel_t'(FAST_THRESHOLD)) begin
            lo_th = '0;
        end else begin
            lo_th = i_win.center - pixel_t'(FAST_THRESHOLD);
        end
        for (int i = 0; i < CIRCLE_POINTS; i++) begin
            bright_w[i] = i_win.circle[i] > hi_th;
            dark_w[i]   = i_win.circle[i] < lo_th;
        end
    end

    // stage 2
    always_comb begin
        bright_len = longest_arc(s1_bright_r);
        dark_len   = longest_arc(s1_dark_r);
        best_len   = (bright_len > dark_len) ? bright_len : dark_len;
        score_w    = (best_len >= arc_len_t'(ARC_MIN)) ? best_len : '0;
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            s1_valid_r  <= 1'b0;
            o_seg_valid <= 1'b0;
        end else begin
            s1_valid_r  <= i_win_valid;
            o_seg_valid <= s1_valid_r;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_win_valid) begin
            s1_bright_r <= bright_w;
            s1_dark_r   <= dark_w;
            s1_pos_r    <= i_win.pos;
            s1_last_r   <= i_win.last;
        end
        if (s1_valid_r) begin
            o_seg.score <= score_w;
            o_seg.pos   <= s1_pos_r;
            o_seg.last  <= s1_last_r;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/fast_border_mask.sv ====
`timescale 1ns/1ns
`default_nettype none

module fast_border_mask
    import fast_pkg::*;
(
    input  wire             i_clk,
    input  wire             i_rst_n,
    input  wire seg_result_t i_seg,
    input  wire             i_seg_valid,
    output logic            o_point_valid,
    output logic            o_corner,
    output arc_len_t        o_score,
    output coord_pair_t     o_coord,
    output logic            o_end
);

    logic     on_border;
    arc_len_t masked_score;

    // circle would reach outside the image near the edges
    always_comb begin
        on_border = (i_seg.pos.x < coord_t'(BORDER)) ||
                    (i_seg.pos.x > coord_t'(IMG_WIDTH - 1 - BORDER)) ||
                    (i_seg.pos.y < coord_t'(BORDER)) ||
                    (i_seg.pos.y > coord_t'(IMG_HEIGHT - 1 - BORDER));
        masked_score = on_border ? '0 : i_seg.score;
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_point_valid <= 1'b0;
            o_corner      <= 1'b0;
            o_end         <= 1'b0;
        end else begin
            o_point_valid <= i_seg_valid;
            o_corner      <= i_seg_valid && (masked_score != '0);
            // end pulse rides with the last position
            o_end         <= i_seg_valid && i_seg.last;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_seg_valid) begin
            o_score <= masked_score;
            o_coord <= i_seg.pos;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/fast_detector.sv ====
`timescale 1ns/1ns
`default_nettype none

module fast_detector
    import fast_pkg::*;
(
    input  wire         i_clk,
    input  wire         i_rst_n,
    input  wire pixel_t i_pixel,
    input  wire         i_valid,
    input  wire         i_start,
    output logic        o_ready,
    output logic        o_point_valid,
    output logic        o_corner,
    output arc_len_t    o_score,
    output coord_pair_t o_coord,
    output logic        o_end
);

    window_t     win;
    logic        win_valid;
    seg_result_t seg;
    logic        seg_valid;

    // circle window from the pixel stream
    fast_window fast_window_i (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_pixel     (i_pixel),
        .i_valid     (i_valid),
        .i_start     (i_start),
        .o_ready     (o_ready),
        .o_win       (win),
        .o_win_valid (win_valid)
    );

    fast_segment_test fast_segment_test_i (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_win       (win),
        .i_win_valid (win_valid),
        .o_seg       (seg),
        .o_seg_valid (seg_valid)
    );

    fast_border_mask fast_border_mask_i (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_seg         (seg),
        .i_seg_valid   (seg_valid),
        .o_point_valid (o_point_valid),
        .o_corner      (o_corner),
        .o_score       (o_score),
        .o_coord       (o_coord),
        .o_end         (o_end)
    );

endmodule

`default_nettype wire

// ==== verif/fast_model.svh ====
pixel_t img [IMG_HEIGHT][IMG_WIDTH];

// radius 3 ring clockwise from the pixel straight above the centre
int ring_dx [16] = '{0, 1, 2, 3, 3, 3, 2, 1, 0, -1, -2, -3, -3, -3, -2, -1};
int ring_dy [16] = '{-3, -3, -2, -1, 0, 1, 2, 3, 3, 3, 2, 1, 0, -1, -2, -3};

// longest run of set marks walking forward from every start point
function automatic int longest_run(input logic [15:0] marks);
    int best;
    int len;
    best = 0;
    for (int s = 0; s < 16; s++) begin
        len = 0;
        while (len < 16 && marks[(s + len) % 16]) begin
            len = len + 1;
        end
        if (len > best) begin
            best = len;
        end
    end
    return best;
endfunction

function automatic arc_len_t model_score(input int x, input int y);
    int          centre;
    int          p;
    int          run;
    logic [15:0] bright;
    logic [15:0] dark;
    if (x < BORDER || x >= IMG_WIDTH - BORDER || y < BORDER || y >= IMG_HEIGHT - BORDER) begin
        return '0;
    end
    centre = int'(img[y][x]);
    for (int k = 0; k < 16; k++) begin
        p = int'(img[y + ring_dy[k]][x + ring_dx[k]]);
        bright[k] = p > centre + FAST_THRESHOLD;
        dark[k]   = p < centre - FAST_THRESHOLD;
    end
    run = longest_run(bright);
    if (longest_run(dark) > run) begin
        run = longest_run(dark);
    end
    if (run < ARC_MIN) begin
        return '0;
    end
    return arc_len_t'(run);
endfunction

// exact arc of given length on a flat ring
task automatic plant_arc(input int x, input int y, input int first, input int len,
                         input pixel_t level);
    int k;
    img[y][x] = 8'd100;
    for (int i = 0; i < 16; i++) begin
        k = (first + i) % 16;
        img[y + ring_dy[k]][x + ring_dx[k]] = (i < len) ? level : 8'd100;
    end
endtask

task automatic make_image(input int frame);
    int     size;
    int     bx;
    int     by;
    pixel_t level;
    for (int y = 0; y < IMG_HEIGHT; y++) begin
        for (int x = 0; x < IMG_WIDTH; x++) begin
            if (frame == 1 && y >= IMG_HEIGHT / 2) begin
                img[y][x] = pixel_t'(next_random());
            end else begin
                img[y][x] = pixel_t'(100 + next_random() % 4);
            end
        end
    end
    // square blobs give corners at their tips
    for (int b = 0; b < 8; b++) begin
        size  = 2 + int'(next_random() % 4);
        bx    = int'(next_random() % (IMG_WIDTH - size + 1));
        by    = int'(next_random() % (IMG_HEIGHT - size + 1));
        level = (b % 2 == 0) ? 8'd235 : 8'd15;
        for (int dy = 0; dy < size; dy++) begin
            for (int dx = 0; dx < size; dx++) begin
                img[by + dy][bx + dx] = level;
            end
        end
    end
    if (frame == 0) begin
        // wrapping arcs and exact 8 and 9 runs in both polarities
        plant_arc(6, 6, 12, 9, 8'd200);
        plant_arc(14, 6, 3, 8, 8'd30);
        plant_arc(22, 6, 10, 8, 8'd200);
        plant_arc(6, 14, 14, 9, 8'd30);
        plant_arc(14, 14, 0, 12, 8'd200);
        plant_arc(22, 14, 5, 16, 8'd30);
    end
endtask

// ==== verif/fast_detector_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module fast_detector_tb
    import fast_pkg::*;
();

    logic        i_clk;
    logic        i_rst_n;
    pixel_t      i_pixel;
    logic        i_valid;
    logic        i_start;
    logic        o_ready;
    logic        o_point_valid;
    logic        o_corner;
    arc_len_t    o_score;
    coord_pair_t o_coord;
    logic        o_end;

    logic [31:0] rng_state = 32'h45f9_72fc;
    int          mismatch_count = 0;
    int          fault_count = 0;
    int          result_idx = 0;
    logic        frame_done = 1'b0;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    `include "fast_model.svh"

    fast_detector fast_detector_i (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_pixel       (i_pixel),
        .i_valid       (i_valid),
        .i_start       (i_start),
        .o_ready       (o_ready),
        .o_point_valid (o_point_valid),
        .o_corner      (o_corner),
        .o_score       (o_score),
        .o_coord       (o_coord),
        .o_end         (o_end)
    );

    always #20 i_clk = ~i_clk;

    task automatic check_point(input coord_pair_t got_pos, input logic got_corner,
                               input arc_len_t got_score, input coord_pair_t exp_pos,
                               input logic exp_corner, input arc_len_t exp_score);
        if (got_pos !== exp_pos || got_corner !== exp_corner || got_score !== exp_score) begin
            mismatch_count++;
            $display("MISMATCH %0t: (%0d,%0d) corner %0b score %0d, expected (%0d,%0d) %0b %0d",
                     $time, got_pos.x, got_pos.y, got_corner, got_score,
                     exp_pos.x, exp_pos.y, exp_corner, exp_score);
        end
    endtask

    task automatic check_end(input logic got, input logic exp, input int index);
        if (got !== exp) begin
            mismatch_count++;
            $display("MISMATCH %0t: o_end %0b at result %0d, expected %0b",
                     $time, got, index, exp);
        end
    endtask

    task automatic check_level(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("MISMATCH %0t: %s is %0b, expected %0b", $time, what, got, exp);
        end
    endtask

    task automatic send_frame(input int gap_level);
        int total;
        total = IMG_WIDTH * IMG_HEIGHT + WINDOW_LEAD;
        for (int k = 0; k < total; k++) begin
            // random idle cycles between accepted pixels
            if (next_random() % 8 < gap_level) begin
                repeat (1 + next_random() % 3) begin
                    @(negedge i_clk);
                    i_valid = 1'b0;
                    i_start = 1'b0;
                    i_pixel = pixel_t'(next_random());
                end
            end
            @(negedge i_clk);
            if (k > 0) begin
                check_level("o_ready during a frame", o_ready, 1'b0);
            end
            i_valid = 1'b1;
            i_start = (k == 0);
            if (k < IMG_WIDTH * IMG_HEIGHT) begin
                i_pixel = img[k / IMG_WIDTH][k % IMG_WIDTH];
            end else begin
                i_pixel = pixel_t'(next_random());
            end
        end
        @(negedge i_clk);
        i_valid = 1'b0;
        i_start = 1'b0;
    endtask

    task automatic wait_ready(output logic ok);
        ok = 1'b0;
        for (int t = 0; t < 100 && !ok; t++) begin
            @(negedge i_clk);
            ok = o_ready;
        end
    endtask

    task automatic wait_frame_done(output logic ok);
        ok = 1'b0;
        for (int t = 0; t < 200 && !ok; t++) begin
            @(posedge i_clk);
            ok = frame_done;
        end
    endtask

    // check each result against the model
    always @(negedge i_clk) begin : monitor
        coord_pair_t exp_pos;
        arc_len_t    exp_score;
        if (o_point_valid) begin
            exp_pos.x = coord_t'(result_idx % IMG_WIDTH);
            exp_pos.y = coord_t'(result_idx / IMG_WIDTH);
            if (result_idx >= IMG_WIDTH * IMG_HEIGHT) begin
                fault_count++;
                $display("result beyond the last image position at %0t", $time);
            end else begin
                exp_score = model_score(result_idx % IMG_WIDTH, result_idx / IMG_WIDTH);
                check_point(o_coord, o_corner, o_score, exp_pos, exp_score != '0, exp_score);
                check_end(o_end, result_idx == IMG_WIDTH * IMG_HEIGHT - 1, result_idx);
            end
            if (o_end) begin
                check_level("o_ready at frame end", o_ready, 1'b1);
                frame_done = 1'b1;
            end
            result_idx = result_idx + 1;
        end else begin
            check_end(o_end, 1'b0, result_idx);
        end
    end

    initial begin : main
        logic ok;
        logic stop;
        i_clk   = 1'b0;
        i_rst_n = 1'b0;
        i_pixel = '0;
        i_valid = 1'b0;
        i_start = 1'b0;
        stop    = 1'b0;
        repeat (2) @(posedge i_clk);
        @(negedge i_clk);
        i_rst_n = 1'b1;
        @(negedge i_clk);
        check_level("o_ready after reset", o_ready, 1'b1);
        check_level("o_point_valid after reset", o_point_valid, 1'b0);
        check_level("o_corner after reset", o_corner, 1'b0);
        check_level("o_end after reset", o_end, 1'b0);
        for (int f = 0; f < 2 && !stop; f++) begin
            make_image(f);
            wait_ready(ok);
            if (!ok) begin
                fault_count++;
                $display("o_ready never rose before frame %0d", f);
                stop = 1'b1;
            end else begin
                result_idx = 0;
                frame_done = 1'b0;
                send_frame(f == 0 ? 2 : 4);
                wait_frame_done(ok);
                if (!ok) begin
                    fault_count++;
                    $display("timed out waiting for the end of frame %0d", f);
                    stop = 1'b1;
                end else if (result_idx != IMG_WIDTH * IMG_HEIGHT) begin
                    fault_count++;
                    $display("frame %0d gave %0d results instead of %0d",
                             f, result_idx, IMG_WIDTH * IMG_HEIGHT);
                end
            end
        end
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, fault_count);
        if (mismatch_count + fault_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+verif
hdl/fast_pkg.sv
hdl/fast_window.sv
hdl/fast_segment_test.sv
hdl/fast_border_mask.sv
hdl/fast_detector.sv
verif/fast_detector_tb.sv

// ==== Bender.yml ====
package:
  name: fast_detector

sources:
  - files:
      - hdl/fast_pkg.sv
      - hdl/fast_window.sv
      - hdl/fast_segment_test.sv
      - hdl/fast_border_mask.sv
      - hdl/fast_detector.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/fast_detector_tb.sv
